//--- all.f
+incdir+src
src/bus_pkg.sv
src/map_pkg.sv
src/req_if.sv
src/credit_fifo.sv
src/sram_bank.sv
src/req_ingress.sv
src/addr_decode.sv
src/periph_exec.sv
src/rsp_egress.sv
src/periph_top.sv
bench/periph_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps
TOP       := periph_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := CHECKS FAILED

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS) $(wildcard src/*.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation reported a failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/periph_tb.sv
`timescale 1ns/100ps
`include "periph_macros.svh"

module periph_tb;
  import bus_pkg::*;
  import map_pkg::*;

  localparam logic [31:0] SEED = 32'hd4175f12;

  // kind 0 exact data, 1 mtime low word, 2 mtime high word.
  typedef struct packed {
    logic [`TAG_W-1:0]  tag;
    logic [`DATA_W-1:0] rdata;
    logic               err;
    logic [1:0]         kind;
  } exp_t;

  logic               clk = 1'b0;
  logic               rst;
  logic               req_valid_i;
  logic               req_op_i;
  logic [`TAG_W-1:0]  req_tag_i;
  logic [`ADDR_W-1:0] req_addr_i;
  logic [`DATA_W-1:0] req_wdata_i;
  logic [`STRB_W-1:0] req_strb_i;
  logic               req_credit_o;
  logic               rsp_valid_o;
  logic [`TAG_W-1:0]  rsp_tag_o;
  logic [`DATA_W-1:0] rsp_rdata_o;
  logic               rsp_err_o;
  logic               rsp_credit_i = 1'b0;
  logic               tx_valid_o;
  logic [7:0]         tx_data_o;

  logic [`DATA_W-1:0] shadow [`SRAM_WORDS];
  exp_t               exp_q [$];
  logic [7:0]         tx_q [$];
  logic [`TAG_W-1:0]  next_tag = '0;
  logic [31:0]        stim = SEED;
  logic [31:0]        coin = SEED;
  logic [31:0]        last_low = '0;
  logic               hold = 1'b0;
  logic               stop = 1'b0;
  int                 errors = 0;
  int                 issued = 0;
  int                 credit_ret = 0;
  int                 rsp_seen = 0;
  int                 grants = 0;
  int                 run_cycles = 0;  // clock edges since reset release.

  periph_top i_periph_top (.*);

  always #5 clk = ~clk;

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic in_sram(input logic [`ADDR_W-1:0] a);
    return (a - SRAM_BASE) < `ADDR_W'(`SRAM_WORDS * 4);
  endfunction

  // 16 words spread over the bank.
  function automatic logic [`ADDR_W-1:0] sram_word(input logic [3:0] k);
    return SRAM_BASE + 32'(k) * 32'd68;
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return a ^ {a[15:0], a[31:16]} ^ 32'h5a5a_0f0f;
  endfunction

  function automatic exp_t ref_rsp(input logic op, input logic [`TAG_W-1:0] tag,
                                   input logic [`ADDR_W-1:0] addr);
    exp_t e;
    e = '{tag: tag, rdata: '0, err: 1'b0, kind: 2'd0};
    if (in_sram(addr)) begin
      if (!op) e.rdata = shadow[addr[SRAM_AW+1:2]];
    end else if ((addr & ~32'h7) == RTC_ADDR) begin
      if (!op) e.kind = addr[2] ? 2'd2 : 2'd1;  // mtime is only bounded.
    end else if ((addr & ~32'h3) != UART_ADDR) begin
      e.err = 1'b1;  // decode error, data zero.
    end
    return e;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Error %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic issue(input logic op, input logic [`ADDR_W-1:0] addr,
                       input logic [`DATA_W-1:0] wdata, input logic [`STRB_W-1:0] strb);
    int waited;
    waited = 0;
    while (!stop && (`REQ_CREDITS + credit_ret - issued) == 0) begin
      @(negedge clk);
      waited++;
      if (waited == 200) begin
        $display("no request credit returned within 200 cycles");
        errors++;
        stop = 1'b1;
      end
    end
    if (!stop) begin
      req_valid_i = 1'b1;
      req_op_i    = op;
      req_tag_i   = next_tag;
      req_addr_i  = addr;
      req_wdata_i = wdata;
      req_strb_i  = strb;
      exp_q.push_back(ref_rsp(op, next_tag, addr));
      if (op && (addr & ~32'h3) == UART_ADDR) tx_q.push_back(wdata[7:0]);
      if (op && in_sram(addr)) begin
        for (int b = 0; b < `STRB_W; b++) begin
          if (strb[b]) shadow[addr[SRAM_AW+1:2]][b*8 +: 8] = wdata[b*8 +: 8];
        end
      end
      next_tag = next_tag + 1'b1;
      issued++;
      @(negedge clk);
      req_valid_i = 1'b0;
    end
  endtask

  task automatic wait_rsp(input int target);
    int waited;
    waited = 0;
    while (!stop && rsp_seen < target) begin
      @(negedge clk);
      waited++;
      if (waited == 200) begin
        $display("no response within 200 cycles");
        errors++;
        stop = 1'b1;
      end
    end
  endtask

  task automatic drain(input int limit);
    int waited;
    waited = 0;
    while (!stop && (exp_q.size() != 0 || tx_q.size() != 0 || rsp_seen != grants)) begin
      @(negedge clk);
      waited++;
      if (waited == limit) begin
        $display("responses still outstanding after %0d cycles", limit);
        errors++;
        stop = 1'b1;
      end
    end
  endtask

  // host side consumes responses and hands credits back at random.
  always @(negedge clk) begin : return_credits
    rsp_credit_i = 1'b0;
    if (!rst && !hold && rsp_seen > grants) begin
      coin = lcg(coin);
      if (coin[31]) begin
        rsp_credit_i = 1'b1;
        grants++;
      end
    end
  end

  always @(posedge clk) begin : compare
    exp_t e;
    if (!rst) begin
      run_cycles++;
      if (req_credit_o) credit_ret++;
      if (tx_valid_o) begin
        if (tx_q.size() == 0) begin
          errors++;
          $display("UART byte 0x%0h sent without a UART write", tx_data_o);
        end else begin
          check("tx_data_o", 32'(tx_data_o), 32'(tx_q.pop_front()));
        end
      end
      if (rsp_valid_o) begin
        rsp_seen++;
        if (rsp_seen > `RSP_CREDITS + grants) begin
          errors++;
          $display("response sent beyond the credits granted by the host");
        end
        if (exp_q.size() == 0) begin
          errors++;
          $display("response with tag 0x%0h arrived with no request pending", rsp_tag_o);
        end else begin
          e = exp_q.pop_front();
          check("rsp_tag_o", 32'(rsp_tag_o), 32'(e.tag));
          check("rsp_err_o", 32'(rsp_err_o), 32'(e.err));
          if (e.kind == 2'd1) begin
            // low word never goes back and never runs ahead of the clock.
            if (rsp_rdata_o < last_low) begin
              check("rsp_rdata_o", rsp_rdata_o, last_low);
            end
            if (rsp_rdata_o > 32'(run_cycles)) begin
              check("rsp_rdata_o", rsp_rdata_o, 32'(run_cycles));
            end
            last_low = rsp_rdata_o;
          end else begin
            check("rsp_rdata_o", rsp_rdata_o, e.rdata);
          end
        end
      end
    end
  end

  initial begin : main
    logic [31:0] r;
    int base;
    rst         = 1'b1;
    req_valid_i = 1'b0;
    req_op_i    = 1'b0;
    req_tag_i   = '0;
    req_addr_i  = '0;
    req_wdata_i = '0;
    req_strb_i  = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check("req_credit_o", 32'(req_credit_o), 32'h0);
    check("rsp_valid_o", 32'(rsp_valid_o), 32'h0);
    check("tx_valid_o", 32'(tx_valid_o), 32'h0);

    for (int k = 0; k < 16; k++) begin
      issue(OP_WRITE, sram_word(4'(k)), fill_word(sram_word(4'(k))), 4'hf);
    end
    for (int k = 0; k < 16; k++) begin
      stim = lcg(stim);
      r    = lcg(stim);
      issue(OP_WRITE, sram_word(4'(k)), stim, r[31:28]);
    end
    for (int k = 0; k < 16; k++) issue(OP_READ, sram_word(4'(k)), '0, '0);

    stim = lcg(stim);
    issue(OP_WRITE, UART_ADDR, stim, 4'h1);
    issue(OP_READ, UART_ADDR, '0, '0);
    repeat (4) issue(OP_READ, RTC_ADDR, '0, '0);
    issue(OP_READ, RTC_ADDR_UP, '0, '0);
    issue(OP_WRITE, RTC_ADDR, 32'hffff_ffff, 4'hf);  // accepted, no effect.
    issue(OP_READ, RTC_ADDR, '0, '0);
    issue(OP_READ, 32'h4000_1000, '0, '0);
    issue(OP_WRITE, 32'ha000_0100, 32'h1234_5678, 4'hf);
    issue(OP_READ, sram_word(4'd5), '0, '0);
    drain(1000);

    // egress uses its two credits, then the host goes quiet.
    hold = 1'b1;
    base = rsp_seen + 2;
    issue(OP_READ, sram_word(4'd3), '0, '0);
    issue(OP_READ, sram_word(4'd9), '0, '0);
    wait_rsp(base);
    for (int k = 0; k < 6; k++) issue(OP_READ, sram_word(4'(k)), '0, '0);
    for (int c = 0; c < 100; c++) @(negedge clk);
    check("rsp_valid_o count", 32'(rsp_seen), 32'(base));
    hold = 1'b0;
    drain(1000);

    for (int k = 0; k < 24; k++) begin
      stim = lcg(stim);
      r    = lcg(stim);
      case (stim[31:30])
        2'd0: issue(OP_READ, sram_word(r[27:24]), '0, '0);
        2'd1: issue(OP_WRITE, sram_word(r[27:24]), r, r[31:28]);
        2'd2: issue(stim[29], stim[28] ? UART_ADDR : RTC_ADDR, r, 4'h1);
        default: issue(stim[29], 32'h6000_0000 + 32'(r[15:4]), r, 4'hf);
      endcase
    end
    drain(1000);
    check("req_credit_o pulses", 32'(credit_ret), 32'(issued));

    $display("summary: %0d errors, %0d requests, %0d responses, %0d request credits",
             errors, issued, rsp_seen, credit_ret);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- src/periph_top.sv
`timescale 1ns/100ps
`include "periph_macros.svh"

module periph_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               req_valid_i,
  input  logic               req_op_i,
  input  logic [`TAG_W-1:0]  req_tag_i,
  input  logic [`ADDR_W-1:0] req_addr_i,
  input  logic [`DATA_W-1:0] req_wdata_i,
  input  logic [`STRB_W-1:0] req_strb_i,
  output logic               req_credit_o,
  output logic               rsp_valid_o,
  output logic [`TAG_W-1:0]  rsp_tag_o,
  output logic [`DATA_W-1:0] rsp_rdata_o,
  output logic               rsp_err_o,
  input  logic               rsp_credit_i,
  output logic               tx_valid_o,
  output logic [7:0]         tx_data_o
);
  import bus_pkg::*;

  logic rsp_valid;
  rsp_t rsp;
  logic rsp_credit;

  req_if ing2dec ();
  req_if dec2exe ();

  req_ingress i_req_ingress (
    .clk, .rst, .req_valid_i, .req_op_i, .req_tag_i, .req_addr_i,
    .req_wdata_i, .req_strb_i, .req_credit_o,
    .out(ing2dec)
  );

  addr_decode i_addr_decode (.clk, .rst, .in(ing2dec), .out(dec2exe));

  periph_exec i_periph_exec (
    .clk, .rst, .in(dec2exe),
    .rsp_valid_o(rsp_valid), .rsp_o(rsp), .rsp_credit_i(rsp_credit),
    .tx_valid_o, .tx_data_o
  );

  rsp_egress i_rsp_egress (
    .clk, .rst,
    .rsp_valid_i(rsp_valid), .rsp_i(rsp), .rsp_credit_o(rsp_credit),
    .rsp_credit_i, .rsp_valid_o, .rsp_tag_o, .rsp_rdata_o, .rsp_err_o
  );

endmodule

//--- src/rsp_egress.sv
`timescale 1ns/100ps
`include "periph_macros.svh"

module rsp_egress (
  input  logic               clk,
  input  logic               rst,
  input  logic               rsp_valid_i,
  input  bus_pkg::rsp_t      rsp_i,
  output logic               rsp_credit_o,
  input  logic               rsp_credit_i,
  output logic               rsp_valid_o,
  output logic [`TAG_W-1:0]  rsp_tag_o,
  output logic [`DATA_W-1:0] rsp_rdata_o,
  output logic               rsp_err_o
);
  import bus_pkg::*;

  localparam int HW = $clog2(`RSP_CREDITS + 1);

  rsp_t          head;
  logic          empty;
  logic          send;
  logic [HW-1:0] host_cnt;

  credit_fifo #(.T(rsp_t), .DEPTH(`RSP_DEPTH)) i_fifo (
    .clk        (clk),
    .rst        (rst),
    .push_i     (rsp_valid_i),
    .push_data_i(rsp_i),
    .pop_i      (send),
    .pop_data_o (head),
    .empty_o    (empty)
  );

  assign send = !empty && (host_cnt != '0);

  // host returns one credit per consumed response.
  always_ff @(posedge clk) begin
    if (rst) begin
      host_cnt <= HW'(`RSP_CREDITS);
    end else begin
      host_cnt <= host_cnt + HW'(rsp_credit_i) - HW'(send);
    end
  end

  assign rsp_valid_o  = send;
  assign rsp_tag_o    = head.tag;
  assign rsp_rdata_o  = head.rdata;
  assign rsp_err_o    = (head.resp != RESP_OKAY);
  assign rsp_credit_o = send;  // slot frees as the head leaves.

endmodule

//--- src/periph_exec.sv
`timescale 1ns/100ps
`include "periph_macros.svh"

module periph_exec (
  input  logic          clk,
  input  logic          rst,
  req_if.sink           in,
  output logic          rsp_valid_o,
  output bus_pkg::rsp_t rsp_o,
  input  logic          rsp_credit_i,
  output logic          tx_valid_o,
  output logic [7:0]    tx_data_o
);
  import bus_pkg::*;
  import map_pkg::*;

  localparam int CW       = $clog2(`RSP_DEPTH + 1);
  localparam bit THROTTLE = (`THROTTLE_EN != 0);

  logic [19:0]        lfsr;
  logic [63:0]        mtime;
  logic [CW-1:0]      credit_cnt;
  logic               rd_pend;
  logic               go;
  logic               fire;
  logic               is_wr;
  logic               sram_sel;
  logic               sram_rd;
  logic [`DATA_W-1:0] sram_rdata;
  logic [`DATA_W-1:0] rdata_d;
  resp_e              resp_d;

  always_ff @(posedge clk) begin
    if (rst) begin
      lfsr  <= `LFSR_SEED;
      mtime <= '0;
    end else begin
      lfsr  <= {lfsr[18:0], lfsr[19] ^ lfsr[18]};
      mtime <= mtime + 64'd1;
    end
  end

  assign go       = THROTTLE ? lfsr[19] : 1'b1;
  assign fire     = in.valid && go && (credit_cnt != '0) && !rd_pend;
  assign in.credit = fire;
  assign is_wr    = (in.req.op == OP_WRITE);
  assign sram_sel = (in.dev == DEV_SRAM);
  assign sram_rd  = fire && sram_sel && !is_wr;

  sram_bank i_sram (
    .clk    (clk),
    .en_i   (fire && sram_sel),
    .we_i   (is_wr),
    .addr_i (in.req.addr[SRAM_AW+1:2]),
    .wdata_i(in.req.wdata),
    .strb_i (in.req.strb),
    .rdata_o(sram_rdata)
  );

  always_comb begin
    rdata_d = '0;
    resp_d  = RESP_OKAY;
    case (in.dev)
      DEV_CLINT: begin
        if (!is_wr) begin
          rdata_d = in.req.addr[2] ? mtime[63:32] : mtime[31:0];
        end
      end
      DEV_NONE: resp_d = RESP_DECERR;
      default:  rdata_d = '0;  // uart reads as zero.
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      credit_cnt  <= CW'(`RSP_DEPTH);
      rd_pend     <= 1'b0;
      rsp_valid_o <= 1'b0;
      tx_valid_o  <= 1'b0;
    end else begin
      credit_cnt  <= credit_cnt - CW'(fire) + CW'(rsp_credit_i);
      rd_pend     <= sram_rd;
      rsp_valid_o <= (fire && !sram_rd) || rd_pend;
      tx_valid_o  <= fire && (in.dev == DEV_UART) && is_wr;
    end
  end

  // sram read data lands one cycle after issue.
  always_ff @(posedge clk) begin
    if (fire) begin
      rsp_o <= '{tag: in.req.tag, rdata: rdata_d, resp: resp_d};
    end else if (rd_pend) begin
      rsp_o.rdata <= sram_rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (fire && (in.dev == DEV_UART) && is_wr) begin
      tx_data_o <= in.req.wdata[7:0];
    end
  end

  // credit taken at issue is still held while the response is out.
  a_rsp_credit: assert property (@(posedge clk) disable iff (rst)
    rsp_valid_o |-> (credit_cnt < CW'(`RSP_DEPTH)))
    else $error("periph_exec: response sent without an egress credit");

endmodule

//--- src/addr_decode.sv
`timescale 1ns/100ps

module addr_decode (
  input logic   clk,
  input logic   rst,
  req_if.sink   in,
  req_if.source out
);
  import bus_pkg::*;
  import map_pkg::*;

  logic valid_q;
  req_t req_q;
  dev_e dev_q;
  dev_e dev_d;

  always_comb begin
    if ((in.req.addr & UART_MASK) == UART_ADDR) begin
      dev_d = DEV_UART;
    end else if ((in.req.addr & CLINT_MASK) == RTC_ADDR) begin
      dev_d = DEV_CLINT;
    end else if ((in.req.addr & SRAM_MASK) == SRAM_BASE) begin
      dev_d = DEV_SRAM;
    end else begin
      dev_d = DEV_NONE;  // decode error.
    end
  end

  always_ff @(posedge clk) begin
    if (in.valid) begin
      req_q <= in.req;
      dev_q <= dev_d;
    end
  end

  // entry stays presented until exec takes it.
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (in.valid) begin
      valid_q <= 1'b1;
    end else if (out.credit) begin
      valid_q <= 1'b0;
    end
  end

  assign out.valid = valid_q;
  assign out.req   = req_q;
  assign out.dev   = dev_q;
  assign in.credit = out.credit;  // single slot frees on consume.

endmodule

//--- src/req_ingress.sv
`timescale 1ns/100ps
`include "periph_macros.svh"

module req_ingress (
  input  logic               clk,
  input  logic               rst,
  input  logic               req_valid_i,
  input  logic               req_op_i,
  input  logic [`TAG_W-1:0]  req_tag_i,
  input  logic [`ADDR_W-1:0] req_addr_i,
  input  logic [`DATA_W-1:0] req_wdata_i,
  input  logic [`STRB_W-1:0] req_strb_i,
  output logic               req_credit_o,
  req_if.source              out
);
  import bus_pkg::*;
  import map_pkg::*;

  localparam int DEC_SLOTS = 1;  // decode register depth.
  localparam int DW = $clog2(DEC_SLOTS + 1);
  localparam int HW = $clog2(`REQ_CREDITS + 1);

  req_t          host_req;
  req_t          head;
  logic          empty;
  logic          pop;
  logic [DW-1:0] dn_cnt;
  logic [HW-1:0] host_cnt;

  assign host_req = '{op: op_e'(req_op_i), tag: req_tag_i, addr: req_addr_i,
                      wdata: req_wdata_i, strb: req_strb_i};

  credit_fifo #(.T(req_t), .DEPTH(`REQ_CREDITS)) i_fifo (
    .clk        (clk),
    .rst        (rst),
    .push_i     (req_valid_i),
    .push_data_i(host_req),
    .pop_i      (pop),
    .pop_data_o (head),
    .empty_o    (empty)
  );

  assign pop = !empty && (dn_cnt != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      dn_cnt   <= DW'(DEC_SLOTS);
      host_cnt <= HW'(`REQ_CREDITS);
    end else begin
      dn_cnt   <= dn_cnt - DW'(pop) + DW'(out.credit);
      host_cnt <= host_cnt - HW'(req_valid_i) + HW'(req_credit_o);
    end
  end

  assign out.valid    = pop;
  assign out.req      = head;
  assign out.dev      = DEV_NONE;  // decoded in the next stage.
  assign req_credit_o = pop;

  a_host_credit: assert property (@(posedge clk) disable iff (rst)
    req_valid_i |-> (host_cnt != '0) || req_credit_o)
    else $error("req_ingress: host issued beyond its credits");

endmodule

//--- src/sram_bank.sv
`timescale 1ns/100ps
`include "periph_macros.svh"

module sram_bank (
  input  logic                        clk,
  input  logic                        en_i,
  input  logic                        we_i,
  input  logic [map_pkg::SRAM_AW-1:0] addr_i,
  input  logic [`DATA_W-1:0]          wdata_i,
  input  logic [`STRB_W-1:0]          strb_i,
  output logic [`DATA_W-1:0]          rdata_o
);

  logic [`DATA_W-1:0] mem [`SRAM_WORDS];

  // byte lanes follow the strobe.
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        for (int b = 0; b < `STRB_W; b++) begin
          if (strb_i[b]) begin
            mem[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end else begin
        rdata_o <= mem[addr_i];  // valid one cycle later.
      end
    end
  end

endmodule

//--- src/credit_fifo.sv
`timescale 1ns/100ps

module credit_fifo #(
  parameter type T     = logic,
  parameter int  DEPTH = 4
) (
  input  logic clk,
  input  logic rst,
  input  logic push_i,
  input  T     push_data_i,
  input  logic pop_i,
  output T     pop_data_o,
  output logic empty_o
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  T              mem [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;

  function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
    if (ptr == PW'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (push_i) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop_i) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      count <= count + CW'(push_i) - CW'(pop_i);
    end
  end

  assign pop_data_o = mem[rd_ptr];  // head is visible before the pop.
  assign empty_o    = (count == '0);

  // upstream credits keep occupancy within DEPTH.
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    push_i |-> (count < CW'(DEPTH)) || pop_i)
    else $error("credit_fifo: push while full");

  a_no_underflow: assert property (@(posedge clk) disable iff (rst)
    pop_i |-> (count != '0))
    else $error("credit_fifo: pop while empty");

endmodule

//--- src/req_if.sv
`timescale 1ns/100ps

interface req_if;
  import bus_pkg::*;
  import map_pkg::*;

  logic valid;
  req_t req;
  dev_e dev;
  logic credit;  // one pulse per freed sink slot.

  modport source (
    output valid,
    output req,
    output dev,
    input  credit
  );

  modport sink (
    input  valid,
    input  req,
    input  dev,
    output credit
  );

endinterface

//--- src/map_pkg.sv
`include "periph_macros.svh"

package map_pkg;

  typedef enum logic [1:0] {
    DEV_UART  = 2'd0,
    DEV_CLINT = 2'd1,
    DEV_SRAM  = 2'd2,
    DEV_NONE  = 2'd3
  } dev_e;

  localparam logic [`ADDR_W-1:0] UART_ADDR   = 32'ha000_03f8;
  localparam logic [`ADDR_W-1:0] RTC_ADDR    = 32'ha000_0048;
  localparam logic [`ADDR_W-1:0] RTC_ADDR_UP = 32'ha000_004c;
  localparam logic [`ADDR_W-1:0] SRAM_BASE   = 32'h8000_0000;

  // word index width into the bank.
  localparam int SRAM_AW = $clog2(`SRAM_WORDS);

  // a window hits when the masked address equals its base.
  localparam logic [`ADDR_W-1:0] UART_MASK  = ~32'h3;
  localparam logic [`ADDR_W-1:0] CLINT_MASK = ~32'h7;  // both mtime words.
  localparam logic [`ADDR_W-1:0] SRAM_MASK  = ~(`ADDR_W'(`SRAM_WORDS * 4 - 1));

endpackage

//--- src/bus_pkg.sv
`include "periph_macros.svh"

package bus_pkg;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } op_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_DECERR = 2'b11
  } resp_e;

  // single beat, no burst fields.
  typedef struct packed {
    op_e                op;
    logic [`TAG_W-1:0]  tag;
    logic [`ADDR_W-1:0] addr;
    logic [`DATA_W-1:0] wdata;
    logic [`STRB_W-1:0] strb;
  } req_t;

  typedef struct packed {
    logic [`TAG_W-1:0]  tag;
    logic [`DATA_W-1:0] rdata;
    resp_e              resp;
  } rsp_t;

endpackage

//--- src/periph_macros.svh
`ifndef PERIPH_MACROS_SVH
`define PERIPH_MACROS_SVH

// bus widths.
`define ADDR_W 32
`define DATA_W 32
`define TAG_W 4
`define STRB_W (`DATA_W / 8)

// storage and flow control.
`define SRAM_WORDS 256
`define REQ_CREDITS 4
`define RSP_CREDITS 2
`define RSP_DEPTH 4

`define THROTTLE_EN 1  // 0 gives fixed device latency.
`define LFSR_SEED 20'd101

`endif
